//--- fp_format_pkg.sv
package fp_format_pkg;

  // --------------------
  // Format constants
  // --------------------
  // IEEE 754 binary32 layout
  localparam int unsigned FP_WIDTH = 32;
  localparam int unsigned EXP_BITS = 8;
  localparam int unsigned MAN_BITS = 23;

  // Raw operand or result word
  typedef logic [FP_WIDTH-1:0] fp_word_t;
  // Biased exponent and trailing mantissa fields
  typedef logic [EXP_BITS-1:0] fp_exp_t;
  typedef logic [MAN_BITS-1:0] fp_man_t;

  // Sign, exponent and mantissa view of one word
  typedef struct packed {
    logic    sign;
    fp_exp_t exponent;
    fp_man_t mantissa;
  } fp_t;

  // Default quiet NaN, positive with only the mantissa MSB set
  localparam fp_t CANONICAL_NAN = '{
    sign:     1'b0,
    exponent: {EXP_BITS{1'b1}},
    mantissa: {1'b1, {(MAN_BITS-1){1'b0}}}
  };

  // --------------------
  // Classification
  // --------------------
  // Per-operand decode flags
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    logic is_quiet;
    logic is_boxed;
  } fp_info_t;

  // One-hot class mask, bit order as in the RISC-V fclass result
  typedef enum logic [9:0] {
    NEGINF     = 10'h001,
    NEGNORM    = 10'h002,
    NEGSUBNORM = 10'h004,
    NEGZERO    = 10'h008,
    POSZERO    = 10'h010,
    POSSUBNORM = 10'h020,
    POSNORM    = 10'h040,
    POSINF     = 10'h080,
    SNAN       = 10'h100,
    QNAN       = 10'h200
  } classmask_e;

endpackage

//--- noncomp_op_pkg.sv
package noncomp_op_pkg;

  // --------------------
  // Operation encoding
  // --------------------
  // Operation group
  typedef enum logic [1:0] {
    SGNJ,
    MINMAX,
    CMP,
    CLASSIFY
  } operation_e;

  // Rounding mode field, reused to select the variant inside a group
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011
  } roundmode_e;

  // Exception flags, invalid down to inexact
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // Request tag, returned unchanged with the response
  localparam int unsigned TAG_BITS = 4;
  typedef logic [TAG_BITS-1:0] tag_t;

  // --------------------
  // Request and response
  // --------------------
  typedef struct packed {
    fp_format_pkg::fp_word_t [1:0] operands;
    logic [1:0]                    is_boxed;
    roundmode_e                    rnd_mode;
    operation_e                    op;
    logic                          op_mod;
    tag_t                          tag;
  } noncomp_req_t;

  typedef struct packed {
    fp_format_pkg::fp_word_t    result;
    status_t                    status;
    logic                       extension_bit;
    fp_format_pkg::classmask_e  class_mask;
    logic                       is_class;
    tag_t                       tag;
  } noncomp_rsp_t;

endpackage

//--- fp_classifier.sv
module fp_classifier (
  input  fp_format_pkg::fp_word_t [1:0] operands_i,
  input  logic                    [1:0] is_boxed_i,
  output fp_format_pkg::fp_info_t [1:0] info_o
);

  // One decoder per operand
  for (genvar i = 0; i < 2; i++) begin : gen_operand
    fp_format_pkg::fp_t value;
    logic               exp_zero;
    logic               exp_ones;
    logic               man_zero;
    logic               is_nan;

    assign value    = fp_format_pkg::fp_t'(operands_i[i]);
    // Field decode
    assign exp_zero = (value.exponent == '0);
    assign exp_ones = (value.exponent == '1);
    assign man_zero = (value.mantissa == '0);

    // A word that is not NaN-boxed counts as a quiet NaN
    assign is_nan = ~is_boxed_i[i] | (exp_ones & ~man_zero);

    assign info_o[i].is_normal     = is_boxed_i[i] & ~exp_zero & ~exp_ones;
    assign info_o[i].is_subnormal  = is_boxed_i[i] & exp_zero & ~man_zero;
    assign info_o[i].is_zero       = is_boxed_i[i] & exp_zero & man_zero;
    assign info_o[i].is_inf        = is_boxed_i[i] & exp_ones & man_zero;
    assign info_o[i].is_nan        = is_nan;
    // Mantissa MSB clear means signalling
    assign info_o[i].is_signalling = is_boxed_i[i] & is_nan & ~value.mantissa[$high(value.mantissa)];
    assign info_o[i].is_quiet      = is_nan & ~info_o[i].is_signalling;
    assign info_o[i].is_boxed      = is_boxed_i[i];
  end

endmodule

//--- noncomp_pipe_reg.sv
module noncomp_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // --------------------
  // Handshake
  // --------------------
  // Accept when empty or when the held item leaves this cycle
  assign ready_o = ready_i | ~valid_q;

  // Valid bit, cleared by reset or flush
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // --------------------
  // Payload
  // --------------------
  // Load only on an actual transfer
  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

//--- noncomp_ops.sv
module noncomp_ops (
  input  noncomp_op_pkg::noncomp_req_t req_i,
  output noncomp_op_pkg::noncomp_rsp_t rsp_o
);

  fp_format_pkg::fp_info_t [1:0] info;
  fp_format_pkg::fp_t            operand_a;
  fp_format_pkg::fp_t            operand_b;
  fp_format_pkg::fp_info_t       info_a;
  fp_format_pkg::fp_info_t       info_b;
  logic                          any_nan;
  logic                          any_snan;
  logic                          operands_equal;
  logic                          a_smaller;
  logic                          sign_a;
  logic                          sign_b;
  fp_format_pkg::fp_t            sgnj_result;
  logic                          sgnj_ext;
  fp_format_pkg::fp_t            minmax_result;
  logic                          cmp_bit;
  logic                          cmp_nv;
  fp_format_pkg::classmask_e     class_mask;

  // Operand decode
  fp_classifier u_classifier (
    .operands_i (req_i.operands),
    .is_boxed_i (req_i.is_boxed),
    .info_o     (info)
  );

  assign operand_a = fp_format_pkg::fp_t'(req_i.operands[0]);
  assign operand_b = fp_format_pkg::fp_t'(req_i.operands[1]);
  assign info_a    = info[0];
  assign info_b    = info[1];

  assign any_nan  = info_a.is_nan | info_b.is_nan;
  assign any_snan = info_a.is_signalling | info_b.is_signalling;

  // --------------------
  // Shared compare terms
  // --------------------
  // +0 and -0 compare equal
  assign operands_equal = (req_i.operands[0] == req_i.operands[1])
                          | (info_a.is_zero & info_b.is_zero);
  // Unsigned order flips once a negative operand is involved
  assign a_smaller = (req_i.operands[0] < req_i.operands[1])
                     ^ (operand_a.sign | operand_b.sign);

  // --------------------
  // Sign injection
  // --------------------
  // Signs of unboxed operands read as positive
  assign sign_a = operand_a.sign & info_a.is_boxed;
  assign sign_b = operand_b.sign & info_b.is_boxed;

  always_comb begin
    sgnj_result = info_a.is_boxed ? operand_a : fp_format_pkg::CANONICAL_NAN;
    case (req_i.rnd_mode)
      noncomp_op_pkg::RNE: sgnj_result.sign = sign_b;
      noncomp_op_pkg::RTZ: sgnj_result.sign = ~sign_b;
      noncomp_op_pkg::RDN: sgnj_result.sign = sign_a ^ sign_b;
      // Passthrough skips the boxing check
      noncomp_op_pkg::RUP: sgnj_result = operand_a;
      default:             sgnj_result = operand_a;
    endcase
  end

  // op_mod asks for integer sign extension of the result
  assign sgnj_ext = req_i.op_mod ? sgnj_result.sign : 1'b1;

  // --------------------
  // Min / max
  // --------------------
  always_comb begin
    if (info_a.is_nan && info_b.is_nan) begin
      minmax_result = fp_format_pkg::CANONICAL_NAN;
    end else if (info_a.is_nan) begin
      minmax_result = operand_b;
    end else if (info_b.is_nan) begin
      minmax_result = operand_a;
    end else begin
      case (req_i.rnd_mode)
        noncomp_op_pkg::RNE: minmax_result = a_smaller ? operand_a : operand_b;
        noncomp_op_pkg::RTZ: minmax_result = a_smaller ? operand_b : operand_a;
        default:             minmax_result = fp_format_pkg::CANONICAL_NAN;
      endcase
    end
  end

  // --------------------
  // Compare
  // --------------------
  always_comb begin
    cmp_bit = 1'b0;
    cmp_nv  = 1'b0;
    if (any_snan) begin
      // Only "not equal" reports true on an sNaN
      cmp_nv  = 1'b1;
      cmp_bit = (req_i.rnd_mode == noncomp_op_pkg::RDN) & req_i.op_mod;
    end else begin
      case (req_i.rnd_mode)
        // LE and LT are signalling, a qNaN is invalid
        noncomp_op_pkg::RNE: begin
          if (any_nan) cmp_nv = 1'b1;
          else cmp_bit = (a_smaller | operands_equal) ^ req_i.op_mod;
        end
        noncomp_op_pkg::RTZ: begin
          if (any_nan) cmp_nv = 1'b1;
          else cmp_bit = (a_smaller & ~operands_equal) ^ req_i.op_mod;
        end
        // EQ is quiet, NaN never equal
        noncomp_op_pkg::RDN: begin
          if (any_nan) cmp_bit = req_i.op_mod;
          else cmp_bit = operands_equal ^ req_i.op_mod;
        end
        default: cmp_bit = 1'b0;
      endcase
    end
  end

  // --------------------
  // Classify
  // --------------------
  always_comb begin
    if (info_a.is_normal) begin
      class_mask = operand_a.sign ? fp_format_pkg::NEGNORM : fp_format_pkg::POSNORM;
    end else if (info_a.is_subnormal) begin
      class_mask = operand_a.sign ? fp_format_pkg::NEGSUBNORM : fp_format_pkg::POSSUBNORM;
    end else if (info_a.is_zero) begin
      class_mask = operand_a.sign ? fp_format_pkg::NEGZERO : fp_format_pkg::POSZERO;
    end else if (info_a.is_inf) begin
      class_mask = operand_a.sign ? fp_format_pkg::NEGINF : fp_format_pkg::POSINF;
    end else if (info_a.is_signalling) begin
      class_mask = fp_format_pkg::SNAN;
    end else begin
      class_mask = fp_format_pkg::QNAN;
    end
  end

  // --------------------
  // Result select
  // --------------------
  always_comb begin
    rsp_o            = '0;
    rsp_o.class_mask = class_mask;
    rsp_o.is_class   = (req_i.op == noncomp_op_pkg::CLASSIFY);
    rsp_o.tag        = req_i.tag;
    unique case (req_i.op)
      noncomp_op_pkg::SGNJ: begin
        rsp_o.result        = fp_format_pkg::fp_word_t'(sgnj_result);
        rsp_o.extension_bit = sgnj_ext;
      end
      noncomp_op_pkg::MINMAX: begin
        rsp_o.result        = fp_format_pkg::fp_word_t'(minmax_result);
        rsp_o.status.NV     = any_snan;
        // Always a float result, keep it NaN-boxed
        rsp_o.extension_bit = 1'b1;
      end
      noncomp_op_pkg::CMP: begin
        rsp_o.result    = fp_format_pkg::fp_word_t'(cmp_bit);
        rsp_o.status.NV = cmp_nv;
      end
      // Mask travels on its own field, result stays zero
      noncomp_op_pkg::CLASSIFY: rsp_o.result = '0;
    endcase
  end

endmodule

//--- fp_noncomp.sv
module fp_noncomp (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         flush_i,
  // Request side
  input  noncomp_op_pkg::noncomp_req_t req_i,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  // Response side
  output noncomp_op_pkg::noncomp_rsp_t rsp_o,
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  // Anything in flight
  output logic                         busy_o
);

  noncomp_op_pkg::noncomp_req_t req_q;
  logic                         req_valid_q;
  logic                         ops_ready;
  noncomp_op_pkg::noncomp_rsp_t rsp_d;

  // --------------------
  // Input stage
  // --------------------
  noncomp_pipe_reg #(
    .payload_t (noncomp_op_pkg::noncomp_req_t)
  ) u_in_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  (req_i),
    .valid_o (req_valid_q),
    .ready_i (ops_ready),
    .data_o  (req_q)
  );

  // Operation logic, purely combinational
  noncomp_ops u_ops (
    .req_i (req_q),
    .rsp_o (rsp_d)
  );

  // --------------------
  // Output stage
  // --------------------
  noncomp_pipe_reg #(
    .payload_t (noncomp_op_pkg::noncomp_rsp_t)
  ) u_out_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (req_valid_q),
    .ready_o (ops_ready),
    .data_i  (rsp_d),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .data_o  (rsp_o)
  );

  // Either stage holding an item
  assign busy_o = req_valid_q | out_valid_o;

endmodule

//--- fp_noncomp_props.sv
module fp_noncomp_props (
  input logic                         clk_i,
  input logic                         rst_n_i,
  input logic                         flush_i,
  input logic                         in_valid_i,
  input logic                         in_ready_o,
  input logic                         out_valid_o,
  input logic                         out_ready_i,
  input noncomp_op_pkg::noncomp_rsp_t rsp_o,
  input logic                         busy_o
);

  // --------------------
  // Reset
  // --------------------
  // Synchronous reset empties the output stage on the next edge
  reset_clears_valid: assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_o)
    else $error("out_valid_o high after a reset edge");

  // --------------------
  // Handshake
  // --------------------
  // A stalled response must not change
  stall_holds_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> $stable(rsp_o))
    else $error("rsp_o changed while stalled");

  // Busy covers the output stage and a request taken on the previous edge
  in_flight_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o || $past(in_valid_i && in_ready_o && !flush_i) |-> busy_o)
    else $error("busy_o low with an item in flight");

endmodule

bind fp_noncomp fp_noncomp_props u_props (.*);

//--- tb_fp_noncomp.sv
module tb_fp_noncomp;

  localparam int unsigned TIMEOUT_CYCLES = 20;

  logic                         clk_i;
  logic                         rst_n_i;
  logic                         flush_i;
  noncomp_op_pkg::noncomp_req_t req_i;
  logic                         in_valid_i;
  logic                         in_ready_o;
  noncomp_op_pkg::noncomp_rsp_t rsp_o;
  logic                         out_valid_o;
  logic                         out_ready_i;
  logic                         busy_o;

  int                           errors;
  int                           tests;
  int                           seed;
  logic                         timed_out;
  noncomp_op_pkg::tag_t         next_tag;
  noncomp_op_pkg::noncomp_rsp_t last_rsp;

  // Directed operand pairs shared by the min/max and compare tests
  fp_format_pkg::fp_word_t vec_a [12] = '{32'h3F800000, 32'hBF800000, 32'hC0000000,
    32'h00000000, 32'h80000000, 32'h3F800000, 32'h7FC00000, 32'hBF800000, 32'h7FC00000,
    32'h7F800001, 32'h3F800000, 32'h00000001};
  fp_format_pkg::fp_word_t vec_b [12] = '{32'h40000000, 32'h3F800000, 32'hBF800000,
    32'h80000000, 32'h00000000, 32'h3F800000, 32'h3F800000, 32'h7FC00000, 32'hFFC00000,
    32'h3F800000, 32'hFF800001, 32'h80000001};
  noncomp_op_pkg::roundmode_e modes [4] = '{noncomp_op_pkg::RNE, noncomp_op_pkg::RTZ,
    noncomp_op_pkg::RDN, noncomp_op_pkg::RUP};

  fp_noncomp fp_noncomp_i (.*);

  // Free-running clock, period 40
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Ends the run once a wait loop gives up
  initial begin
    timed_out = 1'b0;
    wait (timed_out);
    $display("Regression failed");
    $finish;
  end

  // --------------------
  // Reference model
  // --------------------
  function automatic logic nan_of(input fp_format_pkg::fp_word_t w, input logic boxed);
    return !boxed || (w[30:23] == 8'hFF && w[22:0] != '0);
  endfunction

  function automatic logic snan_of(input fp_format_pkg::fp_word_t w, input logic boxed);
    return boxed && w[30:23] == 8'hFF && w[22:0] != '0 && !w[22];
  endfunction

  // Total order on the encodings, -0 sorts below +0
  function automatic logic less_than(input fp_format_pkg::fp_word_t a,
                                     input fp_format_pkg::fp_word_t b);
    if (a[31] != b[31]) return a[31];
    if (a[31]) return a[30:0] > b[30:0];
    return a[30:0] < b[30:0];
  endfunction

  function automatic fp_format_pkg::classmask_e class_of(input fp_format_pkg::fp_word_t w,
                                                         input logic boxed);
    if (nan_of(w, boxed)) return snan_of(w, boxed) ? fp_format_pkg::SNAN : fp_format_pkg::QNAN;
    if (w[30:23] == 8'hFF) return w[31] ? fp_format_pkg::NEGINF : fp_format_pkg::POSINF;
    if (w[30:23] != '0) return w[31] ? fp_format_pkg::NEGNORM : fp_format_pkg::POSNORM;
    if (w[22:0] != '0) return w[31] ? fp_format_pkg::NEGSUBNORM : fp_format_pkg::POSSUBNORM;
    return w[31] ? fp_format_pkg::NEGZERO : fp_format_pkg::POSZERO;
  endfunction

  function automatic noncomp_op_pkg::noncomp_rsp_t model_rsp(
    input noncomp_op_pkg::noncomp_req_t r);
    noncomp_op_pkg::noncomp_rsp_t e;
    fp_format_pkg::fp_word_t      a;
    fp_format_pkg::fp_word_t      b;
    logic                         a_nan;
    logic                         b_nan;
    logic                         snan;
    logic                         lt;
    logic                         eq;
    a     = r.operands[0];
    b     = r.operands[1];
    a_nan = nan_of(a, r.is_boxed[0]);
    b_nan = nan_of(b, r.is_boxed[1]);
    snan  = snan_of(a, r.is_boxed[0]) | snan_of(b, r.is_boxed[1]);
    lt    = less_than(a, b);
    eq    = (a == b) || (a[30:0] == '0 && b[30:0] == '0);
    e            = '0;
    e.tag        = r.tag;
    e.class_mask = class_of(a, r.is_boxed[0]);
    case (r.op)
      noncomp_op_pkg::SGNJ: begin
        if (r.rnd_mode == noncomp_op_pkg::RUP) begin
          e.result = a;
        end else begin
          // Unboxed a reads as the default NaN, unboxed signs read as positive
          e.result = r.is_boxed[0] ? a : fp_format_pkg::CANONICAL_NAN;
          if (r.rnd_mode == noncomp_op_pkg::RNE) e.result[31] = b[31] & r.is_boxed[1];
          else if (r.rnd_mode == noncomp_op_pkg::RTZ) e.result[31] = ~(b[31] & r.is_boxed[1]);
          else e.result[31] = (a[31] & r.is_boxed[0]) ^ (b[31] & r.is_boxed[1]);
        end
        e.extension_bit = r.op_mod ? e.result[31] : 1'b1;
      end
      noncomp_op_pkg::MINMAX: begin
        if (a_nan && b_nan) e.result = fp_format_pkg::CANONICAL_NAN;
        else if (a_nan) e.result = b;
        else if (b_nan) e.result = a;
        else if (r.rnd_mode == noncomp_op_pkg::RNE) e.result = lt ? a : b;
        else e.result = lt ? b : a;
        e.status.NV     = snan;
        e.extension_bit = 1'b1;
      end
      noncomp_op_pkg::CMP: begin
        if (snan) begin
          e.status.NV = 1'b1;
          e.result[0] = (r.rnd_mode == noncomp_op_pkg::RDN) & r.op_mod;
        end else if (r.rnd_mode == noncomp_op_pkg::RDN) begin
          e.result[0] = (a_nan | b_nan) ? r.op_mod : eq ^ r.op_mod;
        end else if (a_nan | b_nan) begin
          e.status.NV = 1'b1;
        end else if (r.rnd_mode == noncomp_op_pkg::RNE) begin
          e.result[0] = (lt | eq) ^ r.op_mod;
        end else begin
          e.result[0] = (lt & ~eq) ^ r.op_mod;
        end
      end
      default: e.is_class = 1'b1;
    endcase
    return e;
  endfunction

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_word(input string name, input fp_format_pkg::fp_word_t got,
                            input fp_format_pkg::fp_word_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_status(input string name, input noncomp_op_pkg::status_t got,
                              input noncomp_op_pkg::status_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_class(input string name, input fp_format_pkg::classmask_e got,
                             input fp_format_pkg::classmask_e exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_tag(input string name, input noncomp_op_pkg::tag_t got,
                           input noncomp_op_pkg::tag_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic compare_rsp(input noncomp_op_pkg::noncomp_rsp_t got,
                             input noncomp_op_pkg::noncomp_rsp_t exp);
    check_word("rsp_o.result", got.result, exp.result);
    check_status("rsp_o.status", got.status, exp.status);
    check_bit("rsp_o.extension_bit", got.extension_bit, exp.extension_bit);
    check_class("rsp_o.class_mask", got.class_mask, exp.class_mask);
    check_bit("rsp_o.is_class", got.is_class, exp.is_class);
    check_tag("rsp_o.tag", got.tag, exp.tag);
  endtask

  // --------------------
  // Drivers
  // --------------------
  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    timed_out = 1'b1;
    // The watchdog process ends the run from here
    wait (timed_out == 1'b0);
  endtask

  // Called 2 time units after an edge, returns the same way
  task automatic send_req(input noncomp_op_pkg::noncomp_req_t r);
    int waited;
    waited     = 0;
    req_i      = r;
    in_valid_i = 1'b1;
    #1;
    while (!in_ready_o) begin
      if (waited == TIMEOUT_CYCLES) report_timeout("in_ready_o");
      waited++;
      @(posedge clk_i);
      #3;
    end
    @(posedge clk_i);
    #2;
    in_valid_i = 1'b0;
  endtask

  task automatic get_rsp(output noncomp_op_pkg::noncomp_rsp_t r);
    int waited;
    waited      = 0;
    out_ready_i = 1'b1;
    #1;
    while (!out_valid_o) begin
      if (waited == TIMEOUT_CYCLES) report_timeout("out_valid_o");
      waited++;
      @(posedge clk_i);
      #3;
    end
    r = rsp_o;
    @(posedge clk_i);
    #2;
  endtask

  function automatic noncomp_op_pkg::noncomp_req_t build_req(
    input noncomp_op_pkg::operation_e op, input noncomp_op_pkg::roundmode_e rnd,
    input logic mod, input fp_format_pkg::fp_word_t a, input fp_format_pkg::fp_word_t b,
    input logic [1:0] boxed);
    noncomp_op_pkg::noncomp_req_t r;
    r.operands = {b, a};
    r.is_boxed = boxed;
    r.rnd_mode = rnd;
    r.op       = op;
    r.op_mod   = mod;
    r.tag      = next_tag;
    next_tag   = next_tag + 1'b1;
    return r;
  endfunction

  // One request through the pipe, checked against the model
  task automatic run_case(input noncomp_op_pkg::operation_e op,
                          input noncomp_op_pkg::roundmode_e rnd, input logic mod,
                          input fp_format_pkg::fp_word_t a, input fp_format_pkg::fp_word_t b,
                          input logic [1:0] boxed);
    noncomp_op_pkg::noncomp_req_t r;
    r = build_req(op, rnd, mod, a, b, boxed);
    send_req(r);
    get_rsp(last_rsp);
    compare_rsp(last_rsp, model_rsp(r));
  endtask

  task automatic report_test(input string name, input int start);
    tests++;
    $display("Test %-14s %s, %0d errors", name, (errors == start) ? "ok" : "FAILED",
             errors - start);
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_reset();
    int start;
    start = errors;
    check_bit("in_ready_o", in_ready_o, 1'b1);
    check_bit("out_valid_o", out_valid_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    report_test("reset", start);
  endtask

  task automatic test_sgnj();
    int start;
    start = errors;
    for (int m = 0; m < 4; m++) begin
      for (int k = 0; k < 2; k++) begin
        run_case(noncomp_op_pkg::SGNJ, modes[m], k[0], 32'h3F800000, 32'hC0000000, 2'b11);
        run_case(noncomp_op_pkg::SGNJ, modes[m], k[0], 32'hBF800000, 32'h40000000, 2'b11);
        // Unboxed b, then unboxed a
        run_case(noncomp_op_pkg::SGNJ, modes[m], k[0], 32'hBF800000, 32'hC0000000, 2'b01);
        run_case(noncomp_op_pkg::SGNJ, modes[m], k[0], 32'hBF800000, 32'hC0000000, 2'b10);
      end
    end
    report_test("sign injection", start);
  endtask

  task automatic test_minmax();
    int          start;
    logic [31:0] r;
    start = errors;
    for (int m = 0; m < 2; m++) begin
      for (int i = 0; i < 12; i++) begin
        run_case(noncomp_op_pkg::MINMAX, modes[m], 1'b0, vec_a[i], vec_b[i], 2'b11);
      end
    end
    for (int i = 0; i < 24; i++) begin
      r = $random(seed);
      run_case(noncomp_op_pkg::MINMAX, modes[r[0]], 1'b0, $random(seed), $random(seed), 2'b11);
    end
    report_test("min/max", start);
  endtask

  task automatic test_cmp();
    int          start;
    logic [31:0] r;
    start = errors;
    for (int m = 0; m < 3; m++) begin
      for (int k = 0; k < 2; k++) begin
        for (int i = 0; i < 12; i++) begin
          run_case(noncomp_op_pkg::CMP, modes[m], k[0], vec_a[i], vec_b[i], 2'b11);
        end
      end
    end
    for (int i = 0; i < 24; i++) begin
      r = $random(seed);
      run_case(noncomp_op_pkg::CMP, modes[r % 3], r[4], $random(seed), $random(seed), 2'b11);
    end
    report_test("compare", start);
  endtask

  task automatic test_classify();
    int                        start;
    fp_format_pkg::fp_word_t   words [10];
    fp_format_pkg::classmask_e masks [10];
    start = errors;
    words = '{32'hFF800000, 32'hBF800000, 32'h80000001, 32'h80000000, 32'h00000000,
              32'h00000001, 32'h3F800000, 32'h7F800000, 32'h7F800001, 32'h7FC00000};
    masks = '{fp_format_pkg::NEGINF, fp_format_pkg::NEGNORM, fp_format_pkg::NEGSUBNORM,
              fp_format_pkg::NEGZERO, fp_format_pkg::POSZERO, fp_format_pkg::POSSUBNORM,
              fp_format_pkg::POSNORM, fp_format_pkg::POSINF, fp_format_pkg::SNAN,
              fp_format_pkg::QNAN};
    for (int i = 0; i < 10; i++) begin
      run_case(noncomp_op_pkg::CLASSIFY, noncomp_op_pkg::RNE, 1'b0, words[i], '0, 2'b11);
      check_class("rsp_o.class_mask", last_rsp.class_mask, masks[i]);
      check_bit("rsp_o.is_class", last_rsp.is_class, 1'b1);
      check_bit("rsp_o.extension_bit", last_rsp.extension_bit, 1'b0);
    end
    report_test("classify", start);
  endtask

  task automatic test_backpressure();
    int                           start;
    int                           n;
    noncomp_op_pkg::noncomp_req_t r;
    noncomp_op_pkg::noncomp_req_t sent [$];
    noncomp_op_pkg::noncomp_rsp_t got;
    start       = errors;
    out_ready_i = 1'b0;
    // Offer requests until the pipe pushes back
    for (n = 0; n < 4; n++) begin
      r          = build_req(noncomp_op_pkg::MINMAX, noncomp_op_pkg::RTZ, 1'b0, vec_a[n],
                             vec_b[n], 2'b11);
      req_i      = r;
      in_valid_i = 1'b1;
      #1;
      if (!in_ready_o) break;
      sent.push_back(r);
      @(posedge clk_i);
      #2;
    end
    @(posedge clk_i);
    #2;
    in_valid_i = 1'b0;
    if (sent.size() != 2) begin
      errors++;
      $display("in_ready_o fell after %0d accepted requests instead of 2", sent.size());
    end
    check_bit("busy_o", busy_o, 1'b1);
    // Drain in acceptance order
    while (sent.size() > 0) begin
      get_rsp(got);
      compare_rsp(got, model_rsp(sent.pop_front()));
    end
    check_bit("out_valid_o", out_valid_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    report_test("back-pressure", start);
  endtask

  task automatic test_flush();
    int                           start;
    noncomp_op_pkg::noncomp_req_t r;
    start       = errors;
    out_ready_i = 1'b0;
    send_req(build_req(noncomp_op_pkg::CMP, noncomp_op_pkg::RNE, 1'b0, vec_a[0], vec_b[0],
                       2'b11));
    send_req(build_req(noncomp_op_pkg::CMP, noncomp_op_pkg::RTZ, 1'b0, vec_a[1], vec_b[1],
                       2'b11));
    check_bit("busy_o", busy_o, 1'b1);
    flush_i = 1'b1;
    @(posedge clk_i);
    #2;
    flush_i = 1'b0;
    check_bit("out_valid_o", out_valid_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    // Next request: in the input stage after acceptance, at the output one edge later
    out_ready_i = 1'b1;
    r = build_req(noncomp_op_pkg::CMP, noncomp_op_pkg::RDN, 1'b1, vec_a[5], vec_b[5], 2'b11);
    send_req(r);
    check_bit("out_valid_o", out_valid_o, 1'b0);
    @(posedge clk_i);
    #2;
    check_bit("out_valid_o", out_valid_o, 1'b1);
    get_rsp(last_rsp);
    compare_rsp(last_rsp, model_rsp(r));
    report_test("flush", start);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    errors      = 0;
    tests       = 0;
    seed        = 11;
    next_tag    = '0;
    rst_n_i     = 1'b0;
    flush_i     = 1'b0;
    req_i       = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    repeat (16) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    test_reset();
    test_sgnj();
    test_minmax();
    test_cmp();
    test_classify();
    test_backpressure();
    test_flush();
    $display("Tests run: %0d, checks failed: %0d", tests, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- src.f
fp_format_pkg.sv
noncomp_op_pkg.sv
fp_classifier.sv
noncomp_pipe_reg.sv
noncomp_ops.sv
fp_noncomp.sv
fp_noncomp_props.sv
tb_fp_noncomp.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fp_noncomp
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FILELIST  := src.f
SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
	  echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
